/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_axi_line_bridge
FILELIST  := src.f
OBJ_DIR   := obj_dir
PASS_MSG  := === PASS ===

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	$(SIM_BIN) | tee /dev/stderr | grep -q -F "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* logic/axi_line_bridge.sv */
`timescale 1ns/1ps

module axi_line_bridge
    import axi_pkg::*;
    import cache_pkg::*;
#(
    parameter int LINE_W = 512,
    parameter int DATA_W = 32
) (
    input  logic              aclk,
    input  logic              aresetn,
    // cache side
    input  line_rd_req_t      i_ic_req,
    input  logic              i_ic_valid,
    output logic [LINE_W-1:0] o_ic_line,
    output logic              o_ic_done,
    input  line_rd_req_t      i_dc_rreq,
    input  logic              i_dc_rvalid,
    output logic [LINE_W-1:0] o_dc_line,
    output logic              o_dc_rdone,
    input  line_wr_req_t      i_dc_wreq,
    input  logic              i_dc_wvalid,
    output logic              o_dc_wdone,
    // AXI master
    output axi_ar_t           o_ar,
    output logic              o_ar_valid,
    input  logic              i_ar_ready,
    input  axi_r_t            i_r,
    input  logic              i_r_valid,
    output logic              o_r_ready,
    output axi_aw_t           o_aw,
    output logic              o_aw_valid,
    input  logic              i_aw_ready,
    output axi_w_t            o_w,
    output logic              o_w_valid,
    input  logic              i_w_ready,
    input  logic              i_b_valid,
    output logic              o_b_ready
);

    // independent read and write paths so one of each can be in flight
    line_read_ctrl #(
        .LINE_W(LINE_W),
        .DATA_W(DATA_W)
    ) u_read_ctrl (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_ic_req   (i_ic_req),
        .i_ic_valid (i_ic_valid),
        .o_ic_line  (o_ic_line),
        .o_ic_done  (o_ic_done),
        .i_dc_rreq  (i_dc_rreq),
        .i_dc_rvalid(i_dc_rvalid),
        .o_dc_line  (o_dc_line),
        .o_dc_rdone (o_dc_rdone),
        .o_ar       (o_ar),
        .o_ar_valid (o_ar_valid),
        .i_ar_ready (i_ar_ready),
        .i_r        (i_r),
        .i_r_valid  (i_r_valid),
        .o_r_ready  (o_r_ready)
    );

    line_write_ctrl #(
        .LINE_W(LINE_W),
        .DATA_W(DATA_W)
    ) u_write_ctrl (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_dc_wreq  (i_dc_wreq),
        .i_dc_wvalid(i_dc_wvalid),
        .o_dc_wdone (o_dc_wdone),
        .o_aw       (o_aw),
        .o_aw_valid (o_aw_valid),
        .i_aw_ready (i_aw_ready),
        .o_w        (o_w),
        .o_w_valid  (o_w_valid),
        .i_w_ready  (i_w_ready),
        .i_b_valid  (i_b_valid),
        .o_b_ready  (o_b_ready)
    );

endmodule

/* logic/axi_pkg.sv */
package axi_pkg;

    localparam int AXI_ID_W   = 4;
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;

    localparam logic [1:0] AXI_BURST_INCR = 2'b01;  // incrementing burst

    // read IDs, one per cache
    localparam logic [AXI_ID_W-1:0] AXI_ID_INSTR = 4'd0;
    localparam logic [AXI_ID_W-1:0] AXI_ID_DATA  = 4'd1;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_ADDR_W-1:0] addr;
        logic [7:0]            len;    // beats minus one
        logic [2:0]            size;   // log2 of bytes per beat
        logic [1:0]            burst;
    } axi_ar_t;

    typedef struct packed {
        logic [AXI_ADDR_W-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
    } axi_aw_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0]   data;
        logic [AXI_DATA_W/8-1:0] strb;
        logic                    last;
    } axi_w_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0]   id;
        logic [AXI_DATA_W-1:0] data;
        logic                  last;
    } axi_r_t;

endpackage

/* logic/cache_pkg.sv */
package cache_pkg;

    // struct widths for the default line size
    localparam int CACHE_ADDR_W = 32;
    localparam int CACHE_LINE_W = 512;
    localparam int CACHE_STRB_W = 4;

    // line read from either cache
    typedef struct packed {
        logic [CACHE_ADDR_W-1:0] addr;
    } line_rd_req_t;

    // dirty line going back to memory
    // strb is one word's worth and gets shifted by addr[1:0]
    typedef struct packed {
        logic [CACHE_ADDR_W-1:0] addr;
        logic [CACHE_LINE_W-1:0] data;
        logic [CACHE_STRB_W-1:0] strb;
    } line_wr_req_t;

endpackage

/* logic/line_assembler.sv */
`timescale 1ns/1ps

module line_assembler #(
    parameter int LINE_W = 512,
    parameter int DATA_W = 32
) (
    input  logic                     aclk,
    input  logic                     aresetn,
    input  logic [DATA_W-1:0]        i_beat,
    input  logic                     i_shift,
    input  logic                     i_flush,
    output logic [LINE_W-DATA_W-1:0] o_buf
);

    logic [LINE_W-DATA_W-1:0] buf_q;
    logic [LINE_W-1:0]        shifted;

    // new beat enters at the top and the oldest beat falls toward bit 0
    assign shifted = {i_beat, buf_q};

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            buf_q <= '0;
        end
        else if (i_flush)
        begin
            buf_q <= '0;  // last beat bypasses the buffer
        end
        else if (i_shift)
        begin
            buf_q <= shifted[LINE_W-1:DATA_W];
        end
    end

    assign o_buf = buf_q;

endmodule

/* logic/line_read_ctrl.sv */
`timescale 1ns/1ps

module line_read_ctrl
    import axi_pkg::*;
    import cache_pkg::*;
#(
    parameter int LINE_W = 512,
    parameter int DATA_W = 32
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  line_rd_req_t      i_ic_req,
    input  logic              i_ic_valid,
    output logic [LINE_W-1:0] o_ic_line,
    output logic              o_ic_done,
    input  line_rd_req_t      i_dc_rreq,
    input  logic              i_dc_rvalid,
    output logic [LINE_W-1:0] o_dc_line,
    output logic              o_dc_rdone,
    output axi_ar_t           o_ar,
    output logic              o_ar_valid,
    input  logic              i_ar_ready,
    input  axi_r_t            i_r,
    input  logic              i_r_valid,
    output logic              o_r_ready
);

    localparam int BEATS = LINE_W / DATA_W;

    typedef enum logic [2:0] {
        R_IDLE,
        R_IADDR,
        R_IDATA,
        R_DADDR,
        R_DDATA
    } rd_state_e;

    rd_state_e                state_q, state_d;
    logic [AXI_ADDR_W-1:0]    addr_q;
    logic [AXI_ID_W-1:0]      id_q;
    logic [LINE_W-DATA_W-1:0] beat_buf;
    logic [LINE_W-1:0]        line;
    logic                     r_fire;
    logic                     r_last_fire;

    assign r_fire      = i_r_valid & o_r_ready;
    assign r_last_fire = r_fire & i_r.last;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
            state_q <= R_IDLE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            R_IDLE:
            begin
                if (i_dc_rvalid)        // data side wins ties
                    state_d = R_DADDR;
                else if (i_ic_valid)
                    state_d = R_IADDR;
            end
            R_IADDR: if (i_ar_ready) state_d = R_IDATA;
            R_DADDR: if (i_ar_ready) state_d = R_DDATA;
            R_IDATA, R_DDATA:
            begin
                if (r_last_fire)
                    state_d = R_IDLE;
            end
            default: state_d = R_IDLE;
        endcase
    end

    // latch the winner while idle
    always_ff @(posedge aclk)
    begin
        if (state_q == R_IDLE)
        begin
            if (i_dc_rvalid)
            begin
                addr_q <= i_dc_rreq.addr;
                id_q   <= AXI_ID_DATA;
            end
            else if (i_ic_valid)
            begin
                addr_q <= i_ic_req.addr;
                id_q   <= AXI_ID_INSTR;
            end
        end
    end

    assign o_ar.id    = id_q;
    assign o_ar.addr  = addr_q;
    assign o_ar.len   = 8'(BEATS - 1);
    assign o_ar.size  = 3'($clog2(DATA_W / 8));
    assign o_ar.burst = AXI_BURST_INCR;

    assign o_ar_valid = (state_q == R_IADDR) || (state_q == R_DADDR);
    assign o_r_ready  = (state_q == R_IDATA) || (state_q == R_DDATA);

    line_assembler #(
        .LINE_W(LINE_W),
        .DATA_W(DATA_W)
    ) u_assembler (
        .aclk   (aclk),
        .aresetn(aresetn),
        .i_beat (i_r.data),
        .i_shift(r_fire),
        .i_flush(r_last_fire),
        .o_buf  (beat_buf)
    );

    assign line = {i_r.data, beat_buf};  // last beat on top

    assign o_ic_done  = (state_q == R_IDATA) & r_last_fire;
    assign o_dc_rdone = (state_q == R_DDATA) & r_last_fire;
    assign o_ic_line  = o_ic_done ? line : '0;
    assign o_dc_line  = o_dc_rdone ? line : '0;

endmodule

/* logic/line_serializer.sv */
`timescale 1ns/1ps

module line_serializer #(
    parameter int LINE_W = 512,
    parameter int DATA_W = 32
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic [LINE_W-1:0] i_line,
    input  logic              i_load,
    input  logic              i_shift,
    output logic [DATA_W-1:0] o_beat
);

    logic [LINE_W-1:0] line_q;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            line_q <= '0;
        end
        else if (i_load)
        begin
            line_q <= i_line;
        end
        else if (i_shift)
        begin
            // next beat moves down with zeros filling from the top
            line_q <= {{DATA_W{1'b0}}, line_q[LINE_W-1:DATA_W]};
        end
    end

    assign o_beat = line_q[DATA_W-1:0];  // current beat on the W bus

endmodule

/* logic/line_write_ctrl.sv */
`timescale 1ns/1ps

module line_write_ctrl
    import axi_pkg::*;
    import cache_pkg::*;
#(
    parameter int LINE_W = 512,
    parameter int DATA_W = 32
) (
    input  logic         aclk,
    input  logic         aresetn,
    input  line_wr_req_t i_dc_wreq,
    input  logic         i_dc_wvalid,
    output logic         o_dc_wdone,
    output axi_aw_t      o_aw,
    output logic         o_aw_valid,
    input  logic         i_aw_ready,
    output axi_w_t       o_w,
    output logic         o_w_valid,
    input  logic         i_w_ready,
    input  logic         i_b_valid,
    output logic         o_b_ready
);

    localparam int BEATS  = LINE_W / DATA_W;
    localparam int BEAT_W = $clog2(BEATS);

    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR,
        W_DATA,
        W_RESP
    } wr_state_e;

    wr_state_e               state_q, state_d;
    logic [AXI_ADDR_W-1:0]   addr_q;
    logic [DATA_W/8-1:0]     strb_q;
    logic [BEAT_W-1:0]       beat_cnt;
    logic [LINE_W-1:0]       line_aligned;
    logic [DATA_W-1:0]       beat;
    logic                    load;
    logic                    w_fire;
    logic                    last_beat;

    assign load      = (state_q == W_IDLE) & i_dc_wvalid;
    assign w_fire    = o_w_valid & i_w_ready;
    assign last_beat = (beat_cnt == BEAT_W'(BEATS - 1));

    // move the line up by addr[1:0] bytes for an unaligned store
    assign line_aligned = i_dc_wreq.data << {i_dc_wreq.addr[1:0], 3'b000};

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
            state_q <= W_IDLE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            W_IDLE: if (i_dc_wvalid) state_d = W_ADDR;
            W_ADDR: if (i_aw_ready) state_d = W_DATA;
            W_DATA: if (w_fire && last_beat) state_d = W_RESP;
            W_RESP: if (i_b_valid) state_d = W_IDLE;
            default: state_d = W_IDLE;
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (load)
        begin
            addr_q <= i_dc_wreq.addr;
            strb_q <= i_dc_wreq.strb << i_dc_wreq.addr[1:0];  // same shift as the data
        end
    end

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
            beat_cnt <= '0;
        else if (load)
            beat_cnt <= '0;
        else if (w_fire)
            beat_cnt <= beat_cnt + 1'b1;  // wraps after the last beat
    end

    line_serializer #(
        .LINE_W(LINE_W),
        .DATA_W(DATA_W)
    ) u_serializer (
        .aclk   (aclk),
        .aresetn(aresetn),
        .i_line (line_aligned),
        .i_load (load),
        .i_shift(w_fire),
        .o_beat (beat)
    );

    assign o_aw.addr  = addr_q;
    assign o_aw.len   = 8'(BEATS - 1);
    assign o_aw.size  = 3'($clog2(DATA_W / 8));
    assign o_aw.burst = AXI_BURST_INCR;

    assign o_w.data = beat;
    assign o_w.strb = strb_q;
    assign o_w.last = last_beat;

    assign o_aw_valid = (state_q == W_ADDR);
    assign o_w_valid  = (state_q == W_DATA);
    assign o_b_ready  = (state_q == W_RESP);
    assign o_dc_wdone = o_b_ready & i_b_valid;

endmodule

/* src.f */
logic/axi_pkg.sv
logic/cache_pkg.sv
logic/line_assembler.sv
logic/line_read_ctrl.sv
logic/line_serializer.sv
logic/line_write_ctrl.sv
logic/axi_line_bridge.sv
test/axi_mem_model.sv
test/tb_axi_line_bridge.sv

/* test/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model
    import axi_pkg::*;
#(
    parameter int          DEPTH    = 1024,          // words
    parameter logic [31:0] PATT_XOR = 32'h5a5a_c3c3
) (
    input  logic    aclk,
    input  logic    aresetn,
    input  axi_ar_t i_ar,
    input  logic    i_ar_valid,
    output logic    o_ar_ready,
    output axi_r_t  o_r,
    output logic    o_r_valid,
    input  logic    i_r_ready,
    input  axi_aw_t i_aw,
    input  logic    i_aw_valid,
    output logic    o_aw_ready,
    input  axi_w_t  i_w,
    input  logic    i_w_valid,
    output logic    o_w_ready,
    output logic    o_b_valid,
    input  logic    i_b_ready
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [31:0]      mem [DEPTH];
    logic             rd_busy, wr_busy, w_done;
    logic [IDX_W-1:0] rd_idx, wr_idx;
    logic [AXI_ID_W-1:0] rd_id;
    logic [1:0]       ar_wait, r_wait, aw_wait, w_wait, b_wait;

    // word value is its byte address xor a constant
    initial
    begin
        for (int i = 0; i < DEPTH; i++)
            mem[i] = (32'(i) << 2) ^ PATT_XOR;
    end

    always @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            o_ar_ready <= 1'b0;
            o_r_valid  <= 1'b0;
            o_r        <= '0;
            o_aw_ready <= 1'b0;
            o_w_ready  <= 1'b0;
            o_b_valid  <= 1'b0;
            rd_busy    <= 1'b0;
            wr_busy    <= 1'b0;
            w_done     <= 1'b0;
            rd_idx     <= '0;
            wr_idx     <= '0;
            rd_id      <= '0;
            {ar_wait, r_wait, aw_wait, w_wait, b_wait} <= '0;
        end
        else
        begin
            o_ar_ready <= 1'b0;  // ready pulses last one cycle
            o_aw_ready <= 1'b0;
            o_w_ready  <= 1'b0;
            // read side
            if (!rd_busy)
            begin
                if (o_ar_ready && i_ar_valid)
                begin
                    rd_busy <= 1'b1;
                    rd_idx  <= i_ar.addr[IDX_W+1:2];
                    rd_id   <= i_ar.id;
                    r_wait  <= 2'($urandom % 4);
                end
                else if (i_ar_valid)
                begin
                    if (ar_wait == 0)
                        o_ar_ready <= 1'b1;
                    else
                        ar_wait <= ar_wait - 1'b1;
                end
            end
            else if (o_r_valid && i_r_ready)
            begin
                o_r_valid <= 1'b0;
                rd_idx    <= rd_idx + 1'b1;
                r_wait    <= 2'($urandom % 4);
                if (o_r.last)
                begin
                    rd_busy <= 1'b0;
                    ar_wait <= 2'($urandom % 4);
                end
            end
            else if (!o_r_valid)
            begin
                if (r_wait == 0)
                begin
                    o_r_valid <= 1'b1;
                    o_r.id    <= rd_id;
                    o_r.data  <= mem[rd_idx];
                    o_r.last  <= (rd_idx[3:0] == 4'hf);  // full 16 beat line
                end
                else
                    r_wait <= r_wait - 1'b1;
            end
            // write side
            if (!wr_busy)
            begin
                if (o_aw_ready && i_aw_valid)
                begin
                    wr_busy <= 1'b1;
                    wr_idx  <= i_aw.addr[IDX_W+1:2];
                    w_wait  <= 2'($urandom % 4);
                end
                else if (i_aw_valid)
                begin
                    if (aw_wait == 0)
                        o_aw_ready <= 1'b1;
                    else
                        aw_wait <= aw_wait - 1'b1;
                end
            end
            else if (!w_done)
            begin
                if (o_w_ready && i_w_valid)
                begin
                    for (int b = 0; b < 4; b++)
                        if (i_w.strb[b])
                            mem[wr_idx][8*b +: 8] <= i_w.data[8*b +: 8];
                    wr_idx <= wr_idx + 1'b1;
                    w_wait <= 2'($urandom % 4);
                    if (i_w.last)
                    begin
                        w_done <= 1'b1;
                        b_wait <= 2'($urandom % 4);
                    end
                end
                else if (w_wait == 0)
                    o_w_ready <= 1'b1;
                else
                    w_wait <= w_wait - 1'b1;
            end
            else if (o_b_valid && i_b_ready)
            begin
                o_b_valid <= 1'b0;
                wr_busy   <= 1'b0;
                w_done    <= 1'b0;
                aw_wait   <= 2'($urandom % 4);
            end
            else if (!o_b_valid)
            begin
                if (b_wait == 0)
                    o_b_valid <= 1'b1;
                else
                    b_wait <= b_wait - 1'b1;
            end
        end
    end

endmodule

/* test/tb_axi_line_bridge.sv */
`timescale 1ns/1ps

module tb_axi_line_bridge
    import axi_pkg::*;
    import cache_pkg::*;
;

    localparam int          LINE_W   = 512;
    localparam int          DATA_W   = 32;
    localparam int          DEPTH    = 1024;
    localparam logic [31:0] PATT_XOR = 32'h5a5a_c3c3;
    localparam int          TIMEOUT  = 2000;

    logic aclk, aresetn;
    line_rd_req_t i_ic_req, i_dc_rreq;
    line_wr_req_t i_dc_wreq;
    logic i_ic_valid, i_dc_rvalid, i_dc_wvalid;
    logic [LINE_W-1:0] o_ic_line, o_dc_line;
    logic o_ic_done, o_dc_rdone, o_dc_wdone;
    axi_ar_t ar;
    axi_r_t  r;
    axi_aw_t aw;
    axi_w_t  w;
    logic ar_valid, ar_ready, r_valid, r_ready, aw_valid, aw_ready;
    logic w_valid, w_ready, b_valid, b_ready;

    logic [31:0]       ref_mem [DEPTH];  // reference copy of memory
    logic [LINE_W-1:0] ic_got, dc_got;
    int                ic_at, dc_at;

    axi_line_bridge #(.LINE_W(LINE_W), .DATA_W(DATA_W)) DUT (
        .aclk(aclk), .aresetn(aresetn),
        .i_ic_req(i_ic_req), .i_ic_valid(i_ic_valid),
        .o_ic_line(o_ic_line), .o_ic_done(o_ic_done),
        .i_dc_rreq(i_dc_rreq), .i_dc_rvalid(i_dc_rvalid),
        .o_dc_line(o_dc_line), .o_dc_rdone(o_dc_rdone),
        .i_dc_wreq(i_dc_wreq), .i_dc_wvalid(i_dc_wvalid), .o_dc_wdone(o_dc_wdone),
        .o_ar(ar), .o_ar_valid(ar_valid), .i_ar_ready(ar_ready),
        .i_r(r), .i_r_valid(r_valid), .o_r_ready(r_ready),
        .o_aw(aw), .o_aw_valid(aw_valid), .i_aw_ready(aw_ready),
        .o_w(w), .o_w_valid(w_valid), .i_w_ready(w_ready),
        .i_b_valid(b_valid), .o_b_ready(b_ready)
    );

    axi_mem_model #(.DEPTH(DEPTH), .PATT_XOR(PATT_XOR)) u_mem (
        .aclk(aclk), .aresetn(aresetn),
        .i_ar(ar), .i_ar_valid(ar_valid), .o_ar_ready(ar_ready),
        .o_r(r), .o_r_valid(r_valid), .i_r_ready(r_ready),
        .i_aw(aw), .i_aw_valid(aw_valid), .o_aw_ready(aw_ready),
        .i_w(w), .i_w_valid(w_valid), .o_w_ready(w_ready),
        .o_b_valid(b_valid), .i_b_ready(b_ready)
    );

    always #2 aclk = ~aclk;

    task automatic stop_with_fail(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [LINE_W-1:0] got,
                               input logic [LINE_W-1:0] exp);
        if (got !== exp)
        begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            stop_with_fail("value mismatch");
        end
    endtask

    // every burst is one full line of 4 byte incrementing beats
    task automatic inspect_addr_channels(input logic dr_pend, input logic [31:0] ic_addr,
                                         input logic [31:0] dr_addr,
                                         input logic [31:0] dw_addr);
        if (ar_valid)
        begin
            check_value("o_ar.id", LINE_W'(ar.id), LINE_W'(dr_pend ? 4'd1 : 4'd0));
            check_value("o_ar.addr", LINE_W'(ar.addr), LINE_W'(dr_pend ? dr_addr : ic_addr));
            check_value("o_ar.len", LINE_W'(ar.len), LINE_W'(LINE_W / DATA_W - 1));
            check_value("o_ar.size", LINE_W'(ar.size), LINE_W'(2));
            check_value("o_ar.burst", LINE_W'(ar.burst), LINE_W'(1));
        end
        if (aw_valid)
        begin
            check_value("o_aw.addr", LINE_W'(aw.addr), LINE_W'(dw_addr));
            check_value("o_aw.len", LINE_W'(aw.len), LINE_W'(LINE_W / DATA_W - 1));
            check_value("o_aw.size", LINE_W'(aw.size), LINE_W'(2));
            check_value("o_aw.burst", LINE_W'(aw.burst), LINE_W'(1));
        end
    endtask

    function automatic logic [LINE_W-1:0] expected_line(input logic [31:0] addr);
        logic [LINE_W-1:0] l;
        for (int k = 0; k < LINE_W / DATA_W; k++)
            l[32*k +: 32] = ref_mem[(addr[11:2] + k) % DEPTH];
        return l;
    endfunction

    // line and strobe move up by addr[1:0] bytes on an unaligned store
    task automatic apply_write(input logic [31:0] addr, input logic [LINE_W-1:0] data,
                               input logic [3:0] strb);
        logic [LINE_W-1:0] moved;
        logic [3:0]        s;
        int                idx;
        moved = data << (8 * addr[1:0]);
        s     = 4'(strb << addr[1:0]);
        for (int k = 0; k < LINE_W / DATA_W; k++)
        begin
            idx = (addr[11:2] + k) % DEPTH;
            for (int b = 0; b < 4; b++)
                if (s[b])
                    ref_mem[idx][8*b +: 8] = moved[32*k + 8*b +: 8];
        end
    endtask

    function automatic logic [LINE_W-1:0] random_line();
        logic [LINE_W-1:0] l;
        for (int k = 0; k < LINE_W / DATA_W; k++)
            l[32*k +: 32] = $urandom;
        return l;
    endfunction

    // raises the chosen requests together and waits for every done
    task automatic run_txn(input logic do_ic, input logic [31:0] ic_addr,
                           input logic do_dr, input logic [31:0] dr_addr,
                           input logic do_dw, input logic [31:0] dw_addr,
                           input logic [LINE_W-1:0] dw_data, input logic [3:0] dw_strb);
        int   cyc;
        logic ic_pend, dr_pend, dw_pend;
        ic_pend = do_ic;
        dr_pend = do_dr;
        dw_pend = do_dw;
        cyc     = 0;
        i_ic_req.addr  = ic_addr;
        i_dc_rreq.addr = dr_addr;
        i_dc_wreq.addr = dw_addr;
        i_dc_wreq.data = dw_data;
        i_dc_wreq.strb = dw_strb;
        i_ic_valid  = do_ic;
        i_dc_rvalid = do_dr;
        i_dc_wvalid = do_dw;
        while (ic_pend || dr_pend || dw_pend)
        begin
            @(negedge aclk);
            cyc++;
            if (cyc > TIMEOUT)
                stop_with_fail("timeout while waiting for a done pulse from the bridge");
            inspect_addr_channels(dr_pend, ic_addr, dr_addr, dw_addr);
            if (o_ic_done)
            begin
                if (!ic_pend)
                    stop_with_fail("instruction done pulsed with no request pending");
                ic_got = o_ic_line;
                ic_at  = cyc;
                ic_pend    = 1'b0;
                i_ic_valid = 1'b0;
            end
            if (o_dc_rdone)
            begin
                if (!dr_pend)
                    stop_with_fail("data read done pulsed with no request pending");
                dc_got = o_dc_line;
                dc_at  = cyc;
                dr_pend     = 1'b0;
                i_dc_rvalid = 1'b0;
            end
            if (o_dc_wdone)
            begin
                if (!dw_pend)
                    stop_with_fail("data write done pulsed with no request pending");
                dw_pend     = 1'b0;
                i_dc_wvalid = 1'b0;
            end
        end
        if (do_dw)
            apply_write(dw_addr, dw_data, dw_strb);
    endtask

    task automatic instr_line_read();
        run_txn(1'b1, 32'h0000_0100, 1'b0, '0, 1'b0, '0, '0, '0);
        check_value("o_ic_line", ic_got, expected_line(32'h0000_0100));
    endtask

    task automatic data_line_read();
        run_txn(1'b0, '0, 1'b1, 32'h0000_0440, 1'b0, '0, '0, '0);
        check_value("o_dc_line", dc_got, expected_line(32'h0000_0440));
    endtask

    task automatic tied_read_priority();
        run_txn(1'b1, 32'h0000_0800, 1'b1, 32'h0000_0880, 1'b0, '0, '0, '0);
        check_value("data_done_first", LINE_W'(dc_at < ic_at), LINE_W'(1));
        check_value("o_ic_line", ic_got, expected_line(32'h0000_0800));
        check_value("o_dc_line", dc_got, expected_line(32'h0000_0880));
    endtask

    task automatic full_write_readback();
        run_txn(1'b0, '0, 1'b0, '0, 1'b1, 32'h0000_0a00, random_line(), 4'hf);
        run_txn(1'b0, '0, 1'b1, 32'h0000_0a00, 1'b0, '0, '0, '0);
        check_value("o_dc_line", dc_got, expected_line(32'h0000_0a00));
    endtask

    task automatic unaligned_write_readback();
        run_txn(1'b0, '0, 1'b0, '0, 1'b1, 32'h0000_0c02, random_line(), 4'b0011);
        run_txn(1'b0, '0, 1'b1, 32'h0000_0c00, 1'b0, '0, '0, '0);
        check_value("o_dc_line", dc_got, expected_line(32'h0000_0c00));
    endtask

    task automatic overlapped_write_read();
        logic [LINE_W-1:0] expected_rd;
        expected_rd = expected_line(32'h0000_0e40);  // read line is untouched by the write
        run_txn(1'b0, '0, 1'b1, 32'h0000_0e40, 1'b1, 32'h0000_0e00, random_line(), 4'hf);
        check_value("o_dc_line", dc_got, expected_rd);
        run_txn(1'b1, 32'h0000_0e00, 1'b0, '0, 1'b0, '0, '0, '0);
        check_value("o_ic_line", ic_got, expected_line(32'h0000_0e00));
    endtask

    initial
    begin
        void'($urandom(32'hfb39_a4f1));
        for (int i = 0; i < DEPTH; i++)
            ref_mem[i] = (32'(i) << 2) ^ PATT_XOR;
        aclk        = 1'b0;
        aresetn     = 1'b0;
        i_ic_req    = '0;
        i_dc_rreq   = '0;
        i_dc_wreq   = '0;
        i_ic_valid  = 1'b0;
        i_dc_rvalid = 1'b0;
        i_dc_wvalid = 1'b0;
        repeat (3) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        instr_line_read();
        data_line_read();
        tied_read_priority();
        full_write_readback();
        unaligned_write_readback();
        overlapped_write_read();
        $display("=== PASS ===");
        $finish;
    end

endmodule
